//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = aes128_pipe_tb
FLIST = aes128_pipe.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: sim clean

# Build, run, then decide by the pass line in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./$(OBJ)/$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

//--- aes128_pipe.f
+incdir+verification
logic/aes_types_pkg.sv
logic/aes_const_pkg.sv
logic/aes_key_stage.sv
logic/aes_round.sv
logic/aes_pipe_ctrl.sv
logic/aes128_pipe_top.sv
verification/aes128_pipe_tb.sv

//--- logic/aes128_pipe_top.sv
`timescale 1ns/100ps

module aes128_pipe_top
    import aes_types_pkg::*;
    import aes_const_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    output logic       in_ready,
    input  aes_req_t   in_req,
    output logic       out_valid,
    input  logic       out_ready,
    output aes_block_t out_data
);

    logic       advance;

    // Entry r is the state after round r, entry 0 the input stage
    aes_block_t state_chain [0:AES_ROUNDS];

    // Entry r is the key for round r, entry 0 the cipher key
    aes_block_t key_chain [0:AES_ROUNDS];

    //////////////////////////////////////////////////////////////////////
    // Flow control
    //////////////////////////////////////////////////////////////////////

    aes_pipe_ctrl i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .advance   (advance),
        .out_valid (out_valid)
    );

    assign in_ready = advance;

    //////////////////////////////////////////////////////////////////////
    // Input stage
    //////////////////////////////////////////////////////////////////////

    // Initial AddRoundKey with the cipher key
    always_ff @(posedge clk) begin
        if (advance) begin
            state_chain[0] <= in_req.plain ^ in_req.key;
        end
    end

    // Key expansion starts on the same edge, one stage ahead of the state
    assign key_chain[0] = in_req.key;

    //////////////////////////////////////////////////////////////////////
    // Round chain
    //////////////////////////////////////////////////////////////////////

    for (genvar r = 1; r <= AES_ROUNDS; r++) begin : g_round
        aes_key_stage #(
            .ROUND (r)
        ) i_key (
            .clk     (clk),
            .advance (advance),
            .key_in  (key_chain[r-1]),
            .key_out (key_chain[r])
        );

        aes_round #(
            .FINAL (r == AES_ROUNDS)
        ) i_round (
            .clk       (clk),
            .advance   (advance),
            .state_in  (state_chain[r-1]),
            .round_key (key_chain[r]),
            .state_out (state_chain[r])
        );
    end

    assign out_data = state_chain[AES_ROUNDS];

endmodule

//--- logic/aes_const_pkg.sv
package aes_const_pkg;

    //////////////////////////////////////////////////////////////////////
    // Pipeline geometry
    //////////////////////////////////////////////////////////////////////

    localparam int AES_ROUNDS       = 10;
    localparam int STAGES_PER_ROUND = 2;

    // Input key addition plus two registers per round
    localparam int PIPE_DEPTH = 1 + AES_ROUNDS * STAGES_PER_ROUND;

    //////////////////////////////////////////////////////////////////////
    // Substitution table
    //////////////////////////////////////////////////////////////////////

    // Row is the upper nibble, column the lower nibble of the input byte
    localparam logic [0:15][7:0] SBOX [16] = '{
        128'h637c777b_f26b6fc5_3001672b_fed7ab76,
        128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
        128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
        128'h04c723c3_1896059a_071280e2_eb27b275,
        128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
        128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
        128'hd0efaafb_434d3385_45f9027f_503c9fa8,
        128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
        128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
        128'h60814fdc_222a9088_46eeb814_de5e0bdb,
        128'he0323a0a_4906245c_c2d3ac62_9195e479,
        128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
        128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
        128'h703eb566_4803f60e_613557b9_86c11d9e,
        128'he1f89811_69d98e94_9b1e87e9_ce5528df,
        128'h8ca1890d_bfe64268_41992d0f_b054bb16
    };

    // Round constants, indexed by round number
    localparam logic [7:0] RCON [1:10] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    //////////////////////////////////////////////////////////////////////
    // GF(2^8) helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [7:0] sub_byte(input logic [7:0] b);
        return SBOX[b[7:4]][b[3:0]];
    endfunction

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

//--- logic/aes_key_stage.sv
`timescale 1ns/100ps

module aes_key_stage
    import aes_types_pkg::*;
    import aes_const_pkg::*;
#(
    parameter int ROUND = 1
) (
    input  logic       clk,
    input  logic       advance,
    input  aes_block_t key_in,
    output aes_block_t key_out
);

    // Running XOR of the previous columns, round constant folded into column 0
    aes_word_t  w0;
    aes_word_t  w1;
    aes_word_t  w2;
    aes_word_t  w3;
    aes_word_t  rot_sub_d;

    aes_block_t chain_q;
    aes_word_t  rot_sub_q;

    assign w0 = key_in.words[0] ^ {RCON[ROUND], 24'h000000};
    assign w1 = w0 ^ key_in.words[1];
    assign w2 = w1 ^ key_in.words[2];
    assign w3 = w2 ^ key_in.words[3];

    // RotWord then SubWord on the last column (bytes 12..15)
    assign rot_sub_d = {
        sub_byte(key_in.bytes[13]),
        sub_byte(key_in.bytes[14]),
        sub_byte(key_in.bytes[15]),
        sub_byte(key_in.bytes[12])
    };

    //////////////////////////////////////////////////////////////////////
    // Stage one
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (advance) begin
            chain_q   <= {w0, w1, w2, w3};
            rot_sub_q <= rot_sub_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage two
    //////////////////////////////////////////////////////////////////////

    // Every column of the next key picks up the same transformed word
    always_ff @(posedge clk) begin
        if (advance) begin
            key_out <= {chain_q.words[0] ^ rot_sub_q,
                        chain_q.words[1] ^ rot_sub_q,
                        chain_q.words[2] ^ rot_sub_q,
                        chain_q.words[3] ^ rot_sub_q};
        end
    end

endmodule

//--- logic/aes_pipe_ctrl.sv
`timescale 1ns/100ps

module aes_pipe_ctrl
    import aes_const_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic out_ready,
    output logic advance,
    output logic out_valid
);

    // One valid bit per register stage, oldest block at the top
    logic [PIPE_DEPTH-1:0] valid_q;

    assign out_valid = valid_q[PIPE_DEPTH-1];

    // Whole pipe moves unless the last block is stuck at the output
    assign advance = out_ready | ~valid_q[PIPE_DEPTH-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q <= {valid_q[PIPE_DEPTH-2:0], in_valid};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Handshake checks
    //////////////////////////////////////////////////////////////////////

    a_out_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid)
        else $error("out_valid dropped before the result was taken");

    // An empty output slot never blocks the pipe
    a_empty_moves: assert property (@(posedge clk) disable iff (rst)
        !out_valid |-> advance)
        else $error("pipe stalled with nothing at the output");

    a_reset_empty: assert property (@(posedge clk) rst |=> valid_q == '0)
        else $error("blocks still in flight after reset");

endmodule

//--- logic/aes_round.sv
`timescale 1ns/100ps

module aes_round
    import aes_types_pkg::*;
    import aes_const_pkg::*;
#(
    parameter bit FINAL = 1'b0
) (
    input  logic       clk,
    input  logic       advance,
    input  aes_block_t state_in,
    input  aes_block_t round_key,
    output aes_block_t state_out
);

    aes_block_t shifted_d;
    aes_block_t shifted_q;
    aes_block_t mixed_d;

    // MixColumns on one column
    function automatic aes_word_t mix_column(input aes_word_t col);
        aes_byte_t a0;
        aes_byte_t a1;
        aes_byte_t a2;
        aes_byte_t a3;
        aes_byte_t d0;
        aes_byte_t d1;
        aes_byte_t d2;
        aes_byte_t d3;
        {a0, a1, a2, a3} = col;
        d0 = xtime(a0);
        d1 = xtime(a1);
        d2 = xtime(a2);
        d3 = xtime(a3);
        // 3*a is written as 2*a ^ a
        return {d0 ^ d1 ^ a1 ^ a2 ^ a3,
                a0 ^ d1 ^ d2 ^ a2 ^ a3,
                a0 ^ a1 ^ d2 ^ d3 ^ a3,
                d0 ^ a0 ^ a1 ^ a2 ^ d3};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stage one: SubBytes and ShiftRows
    //////////////////////////////////////////////////////////////////////

    // Row r of column c comes from column c + r
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted_d.bytes[4*c + r] = sub_byte(state_in.bytes[4*((c + r) % 4) + r]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            shifted_q <= shifted_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage two: MixColumns and AddRoundKey
    //////////////////////////////////////////////////////////////////////

    // Final round has no column mixing
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            if (FINAL) begin
                mixed_d.words[c] = shifted_q.words[c] ^ round_key.words[c];
            end else begin
                mixed_d.words[c] = mix_column(shifted_q.words[c]) ^ round_key.words[c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            state_out <= mixed_d;
        end
    end

    // A stalled pipe must not disturb the block waiting downstream
    a_hold_on_stall: assert property (@(posedge clk) !advance |=> $stable(state_out))
        else $error("round output changed while the pipe was stalled");

endmodule

//--- logic/aes_types_pkg.sv
package aes_types_pkg;

    //////////////////////////////////////////////////////////////////////
    // Basic AES data units
    //////////////////////////////////////////////////////////////////////

    // One state byte
    typedef logic [7:0] aes_byte_t;

    // One state column, row 0 in the top byte
    typedef logic [31:0] aes_word_t;

    //////////////////////////////////////////////////////////////////////
    // 128-bit block
    //////////////////////////////////////////////////////////////////////

    // Same 128 bits seen as columns or as bytes
    // Index 0 sits at the most significant end in both views
    // Byte 4*c + r is row r of column c
    typedef union packed {
        aes_word_t [0:3]  words;
        aes_byte_t [0:15] bytes;
    } aes_block_t;

    //////////////////////////////////////////////////////////////////////
    // Input request
    //////////////////////////////////////////////////////////////////////

    // Plaintext and cipher key enter together
    // Each block brings its own key into the pipe
    typedef struct packed {
        aes_block_t plain;
        aes_block_t key;
    } aes_req_t;

endpackage

//--- verification/aes128_ref_model.svh
`ifndef AES128_REF_MODEL_SVH
`define AES128_REF_MODEL_SVH

// Product in GF(2^8) with the AES polynomial, shift and add
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] x;
    acc = 8'h00;
    x   = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            acc = acc ^ x;
        end
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return acc;
endfunction

// S-box built from its definition, inverse then affine map
function automatic logic [7:0] sbox_value(input logic [7:0] a);
    logic [7:0] inv;
    logic [7:0] p;
    inv = 8'h01;
    p   = a;
    // a^254 is the inverse, zero stays zero
    for (int i = 0; i < 7; i++) begin
        p   = gf_mul(p, p);
        inv = gf_mul(inv, p);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
        ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

// Straight AES-128 encryption on a row by column state
function automatic aes_block_t ref_encrypt(input aes_block_t plain, input aes_block_t key);
    logic [127:0] pt;
    logic [127:0] kt;
    logic [127:0] ct;
    logic [31:0]  w [44];
    logic [31:0]  t;
    logic [7:0]   rc;
    logic [7:0]   st [4][4];
    logic [7:0]   sh [4][4];
    pt = plain;
    kt = key;
    rc = 8'h01;
    for (int i = 0; i < 4; i++) begin
        w[i] = kt[127 - 32*i -: 32];
    end
    for (int i = 4; i < 4 * (AES_ROUNDS + 1); i++) begin
        t = w[i-1];
        if (i % 4 == 0) begin
            t = {sbox_value(t[23:16]), sbox_value(t[15:8]),
                 sbox_value(t[7:0]), sbox_value(t[31:24])} ^ {rc, 24'h000000};
            rc = gf_mul(rc, 8'h02);
        end
        w[i] = w[i-4] ^ t;
    end
    for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
            st[r][c] = pt[127 - 8*(4*c + r) -: 8] ^ w[c][31 - 8*r -: 8];
        end
    end
    for (int rnd = 1; rnd <= AES_ROUNDS; rnd++) begin
        // Row r rotates left by r
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                sh[r][c] = sbox_value(st[r][(c + r) % 4]);
            end
        end
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                if (rnd == AES_ROUNDS) begin
                    st[r][c] = sh[r][c];
                end else begin
                    st[r][c] = gf_mul(sh[r][c], 8'h02) ^ gf_mul(sh[(r + 1) % 4][c], 8'h03)
                        ^ sh[(r + 2) % 4][c] ^ sh[(r + 3) % 4][c];
                end
                st[r][c] = st[r][c] ^ w[4*rnd + c][31 - 8*r -: 8];
            end
        end
    end
    for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
            ct[127 - 8*(4*c + r) -: 8] = st[r][c];
        end
    end
    return ct;
endfunction

`endif

//--- verification/aes128_pipe_tb.sv
`timescale 1ns/100ps

module aes128_pipe_tb
    import aes_types_pkg::*;
    import aes_const_pkg::*;
();

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic       in_ready;
    aes_req_t   in_req;
    logic       out_valid;
    logic       out_ready;
    aes_block_t out_data;

    typedef struct packed {
        aes_block_t plain;
        aes_block_t key;
        aes_block_t cipher;
    } vec_t;

    vec_t       rows [16];
    aes_block_t expq [$];
    integer     seed = 32'ha8d9_7caf;

    `include "aes128_ref_model.svh"

    aes128_pipe_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_block(input aes_block_t got, input aes_block_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] t=%0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] t=%0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            fail_run($sformatf("[ERROR] t=%0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic fill_table();
        rows[0].plain  = 128'h00112233445566778899aabbccddeeff;
        rows[0].key    = 128'h000102030405060708090a0b0c0d0e0f;
        rows[0].cipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        rows[1].plain  = 128'h3243f6a8885a308d313198a2e0370734;
        rows[1].key    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
        rows[1].cipher = 128'h3925841d02dc09fbdc118597196a0b32;
        for (int i = 0; i < 2; i++) begin
            check_block(ref_encrypt(rows[i].plain, rows[i].key), rows[i].cipher,
                        "reference model on standard vector");
        end
        for (int i = 2; i < $size(rows); i++) begin
            for (int w = 0; w < 4; w++) begin
                rows[i].plain.words[w] = $random(seed);
                rows[i].key.words[w]   = $random(seed);
            end
        end
        // Rows 2 and 3 share one plaintext
        rows[3].plain = rows[2].plain;
        for (int i = 2; i < $size(rows); i++) begin
            rows[i].cipher = ref_encrypt(rows[i].plain, rows[i].key);
        end
    endtask

    // Sink held not ready so in_ready depends on the empty pipe alone
    task automatic reset_dut();
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        #1;
        check_flag(out_valid, 1'b0, "out_valid after reset");
        check_flag(in_ready, 1'b1, "in_ready after reset");
    endtask

    // One block alone, latency counted in edges from the accepting edge
    task automatic send_single(input int idx);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        in_valid     = 1'b1;
        in_req.plain = rows[idx].plain;
        in_req.key   = rows[idx].key;
        out_ready    = 1'b1;
        #1;
        check_flag(in_ready, 1'b1, "in_ready with empty pipe");
        do begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            #1;
            cycles++;
            if (cycles > 4 * PIPE_DEPTH) begin
                fail_run($sformatf("Timed out waiting for the result of row %0d", idx));
            end
        end while (!out_valid);
        // Input stage plus two registers for each of ten rounds
        check_count(cycles, 21, "edges from acceptance to out_valid");
        check_block(out_data, rows[idx].cipher, $sformatf("row %0d ciphertext", idx));
        @(posedge clk);
        #2;
        check_flag(out_valid, 1'b0, "out_valid after single result");
    endtask

    // Rows first..last back to back, sink ready fixed high or random
    task automatic run_stream(input int first, input int last, input bit rand_ready);
        int          next;
        int          got;
        int          idle;
        bit          was_stalled;
        aes_block_t  held;
        logic [31:0] rnd;
        next        = first;
        got         = 0;
        idle        = 0;
        was_stalled = 1'b0;
        held        = '0;
        while (got < last - first + 1) begin
            @(posedge clk);
            #1;
            in_valid = (next <= last);
            if (next <= last) begin
                in_req.plain = rows[next].plain;
                in_req.key   = rows[next].key;
            end
            rnd       = $random(seed);
            out_ready = rand_ready ? rnd[0] : 1'b1;
            #1;
            idle++;
            if (was_stalled) begin
                check_flag(out_valid, 1'b1, "out_valid while stalled");
                check_block(out_data, held, "out_data while stalled");
            end
            if (out_valid && !out_ready) begin
                check_flag(in_ready, 1'b0, "in_ready while output stalled");
            end
            if (!rand_ready && in_valid) begin
                check_flag(in_ready, 1'b1, "in_ready with sink always ready");
            end
            // No gaps once a burst has started coming out
            if (!rand_ready && got > 0) begin
                check_flag(out_valid, 1'b1, "out_valid inside back-to-back burst");
            end
            if (in_valid && in_ready) begin
                expq.push_back(rows[next].cipher);
                next++;
                idle = 0;
            end
            if (out_valid && out_ready) begin
                if (expq.size() == 0) begin
                    fail_run("A result came out with no block in flight");
                end
                check_block(out_data, expq.pop_front(), $sformatf("result %0d", got));
                got++;
                idle = 0;
            end
            was_stalled = out_valid && !out_ready;
            held        = out_data;
            if (idle > 10 * PIPE_DEPTH) begin
                fail_run("Timed out waiting for the stream to make progress");
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset_dut();
        fill_table();
        send_single(0);
        send_single(1);
        run_stream(0, $size(rows) - 1, 1'b0);
        run_stream(0, $size(rows) - 1, 1'b1);
        // Same plaintext, two keys, adjacent cycles
        run_stream(2, 3, 1'b0);
        @(posedge clk);
        #2;
        if (expq.size() != 0 || out_valid) begin
            fail_run("Results were left in the pipe at the end of the run");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule
